//--- design/lc3b_cache_pkg.sv
package lc3b_cache_pkg;

	//////////////////////////////////////////////////
	// CPU side
	//////////////////////////////////////////////////

	typedef logic [15:0] lc3b_word; // one CPU word or one byte address.

	typedef logic [1:0] lc3b_mem_wmask; // one enable per byte of a word.

	//////////////////////////////////////////////////
	// address fields
	//////////////////////////////////////////////////

	// tag, index and offset together make up a full lc3b_word address.
	typedef logic [8:0] dcache_tag;

	typedef logic [2:0] dcache_index; // eight sets.

	typedef logic [3:0] dcache_offset; // sixteen bytes per line.

	//////////////////////////////////////////////////
	// memory side and control
	//////////////////////////////////////////////////

	typedef logic [127:0] pmem_l1_bus; // a whole line of eight words.

	typedef enum logic [1:0]
	{
		idle,
		check,
		writeback,
		allocate
	} dcache_state_t;

endpackage

//--- design/dcache_ctrl_if.sv
interface dcache_ctrl_if;

	logic addr_reg_load; // captures the request address for memory traffic.
	logic valid_in; // value written into the valid bit of a way.
	logic dirty_datain; // value written into the dirty bit of a way.
	logic datain_sel; // 0 takes the line from memory, 1 takes the merged line.
	logic write_enable;
	logic cache_allocate; // steers the array write to the LRU way.
	logic pmem_address_sel; // 1 addresses the victim line for write-back.

	logic cache_hit;
	logic dirtyout; // dirty bit of the LRU way of the addressed set.

	modport control
	(
		output addr_reg_load,
		output valid_in,
		output dirty_datain,
		output datain_sel,
		output write_enable,
		output cache_allocate,
		output pmem_address_sel,
		input cache_hit,
		input dirtyout
	);

	modport datapath
	(
		input addr_reg_load,
		input valid_in,
		input dirty_datain,
		input datain_sel,
		input write_enable,
		input cache_allocate,
		input pmem_address_sel,
		output cache_hit,
		output dirtyout
	);

endinterface

//--- design/cache_array.sv
module cache_array
#(
	parameter int width = 1,
	parameter int index_width = 3
)
(
	input logic clk,
	input logic rst_n,
	input logic [index_width-1:0] index,
	input logic write,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] entry [2**index_width];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 2**index_width; i++)
				entry[i] <= '0;
		end
		else if (write)
			entry[index] <= datain;
	end

	assign dataout = entry[index]; // read is combinational.

	// data written at one edge is what the same set reads back after it.
	a_write_readback: assert property (@(posedge clk) disable iff (!rst_n)
		write |=> (index != $past(index)) || (dataout == $past(datain)))
		else $error("array readback differs from the data written.");

endmodule

//--- design/dcache_datapath.sv
module dcache_datapath
(
	input logic clk,
	input logic rst_n,
	dcache_ctrl_if.datapath ctrl,
	input logic mem_read,
	input logic mem_write,
	input lc3b_cache_pkg::lc3b_word mem_address,
	input lc3b_cache_pkg::lc3b_word mem_wdata,
	input lc3b_cache_pkg::lc3b_mem_wmask mem_byte_enable,
	output lc3b_cache_pkg::lc3b_word mem_rdata,
	output lc3b_cache_pkg::lc3b_word pmem_address,
	input lc3b_cache_pkg::pmem_l1_bus pmem_rdata,
	output lc3b_cache_pkg::pmem_l1_bus pmem_wdata
);
	import lc3b_cache_pkg::*;

	localparam int word_bits = $bits(lc3b_word);
	localparam int offset_bits = $bits(dcache_offset);
	localparam dcache_offset line_start = '0;

	dcache_tag tag;
	dcache_index index;
	dcache_offset offset;
	logic [offset_bits-2:0] word_sel;

	lc3b_word addr_reg;

	pmem_l1_bus data_out [2];
	dcache_tag tag_out [2];
	logic [1:0] valid_out;
	logic [1:0] dirty_out;
	logic [1:0] way_hit;
	logic [1:0] way_write;

	logic hit_way;
	logic lru_way;
	logic write_way;
	pmem_l1_bus hit_line;
	pmem_l1_bus line_merge;
	pmem_l1_bus line_in;

	logic lru_write_d;
	logic lru_write_q;

	//////////////////////////////////////////////////
	// address split and request register
	//////////////////////////////////////////////////

	assign {tag, index, offset} = mem_address;
	assign word_sel = offset[offset_bits-1:1]; // bit 0 picks the byte.

	always_ff @(posedge clk)
	begin
		if (ctrl.addr_reg_load)
			addr_reg <= mem_address;
	end

	//////////////////////////////////////////////////
	// per-way storage
	//////////////////////////////////////////////////

	for (genvar w = 0; w < 2; w++)
	begin : g_way
		cache_array #(.width($bits(pmem_l1_bus)), .index_width($bits(dcache_index))) i_data
		(
			.clk, .rst_n, .index,
			.write(way_write[w]), .datain(line_in), .dataout(data_out[w])
		);

		cache_array #(.width($bits(dcache_tag)), .index_width($bits(dcache_index))) i_tag
		(
			.clk, .rst_n, .index,
			.write(way_write[w]), .datain(tag), .dataout(tag_out[w])
		);

		cache_array #(.width(1), .index_width($bits(dcache_index))) i_valid
		(
			.clk, .rst_n, .index,
			.write(way_write[w]), .datain(ctrl.valid_in), .dataout(valid_out[w])
		);

		cache_array #(.width(1), .index_width($bits(dcache_index))) i_dirty
		(
			.clk, .rst_n, .index,
			.write(way_write[w]), .datain(ctrl.dirty_datain), .dataout(dirty_out[w])
		);

		assign way_hit[w] = valid_out[w] & (tag_out[w] == tag);
	end

	//////////////////////////////////////////////////
	// hit detection and replacement
	//////////////////////////////////////////////////

	assign ctrl.cache_hit = |way_hit;
	assign hit_way = way_hit[1]; // way 0 unless way 1 matches.

	// a 1 here marks way 1 as the one to replace.
	cache_array #(.width(1), .index_width($bits(dcache_index))) i_lru
	(
		.clk, .rst_n, .index,
		.write(lru_write_d & ~lru_write_q), .datain(~hit_way), .dataout(lru_way)
	);

	assign lru_write_d = ctrl.cache_hit & (mem_read | mem_write);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			lru_write_q <= 1'b0;
		else
			lru_write_q <= lru_write_d;
	end

	assign write_way = ctrl.cache_allocate ? lru_way : hit_way;
	assign way_write = ctrl.write_enable ? (2'b01 << write_way) : 2'b00;

	assign ctrl.dirtyout = dirty_out[lru_way];

	//////////////////////////////////////////////////
	// data paths
	//////////////////////////////////////////////////

	assign hit_line = data_out[hit_way];
	assign mem_rdata = hit_line[word_sel*word_bits +: word_bits];

	always_comb
	begin
		line_merge = hit_line;
		for (int b = 0; b < $bits(lc3b_mem_wmask); b++)
		begin
			if (mem_byte_enable[b])
				line_merge[word_sel*word_bits + b*8 +: 8] = mem_wdata[b*8 +: 8];
		end
	end

	assign line_in = ctrl.datain_sel ? line_merge : pmem_rdata;

	assign pmem_wdata = data_out[lru_way]; // the victim line.

	assign pmem_address = ctrl.pmem_address_sel ?
		{tag_out[lru_way], index, line_start} :
		{addr_reg[word_bits-1:offset_bits], line_start};

	// allocation only fills the LRU way on a miss, so a tag lives in one way.
	a_single_hit: assert property (@(posedge clk) disable iff (!rst_n) !(&way_hit))
		else $error("both ways hit on the same address.");

endmodule

//--- design/dcache_control.sv
module dcache_control
(
	input logic clk,
	input logic rst_n,
	dcache_ctrl_if.control ctrl,
	input logic mem_read,
	input logic mem_write,
	output logic mem_resp,
	input logic pmem_resp,
	output logic pmem_read,
	output logic pmem_write
);
	import lc3b_cache_pkg::*;

	dcache_state_t state;
	dcache_state_t next_state;
	logic request;

	assign request = mem_read | mem_write;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= idle;
		else
			state <= next_state;
	end

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			idle:
			begin
				if (request)
					next_state = check;
			end
			check:
			begin
				if (!request || ctrl.cache_hit)
					next_state = idle;
				else if (ctrl.dirtyout)
					next_state = writeback; // victim must reach memory first.
				else
					next_state = allocate;
			end
			writeback:
			begin
				if (pmem_resp)
					next_state = allocate;
			end
			allocate:
			begin
				if (pmem_resp)
					next_state = check; // the refilled line hits on the next cycle.
			end
			default:
				next_state = idle;
		endcase
	end

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////

	always_comb
	begin
		ctrl.addr_reg_load = 1'b0;
		ctrl.valid_in = 1'b0;
		ctrl.dirty_datain = 1'b0;
		ctrl.datain_sel = 1'b0;
		ctrl.write_enable = 1'b0;
		ctrl.cache_allocate = 1'b0;
		ctrl.pmem_address_sel = 1'b0;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		case (state)
			idle:
				ctrl.addr_reg_load = 1'b1;
			check:
			begin
				mem_resp = request & ctrl.cache_hit;
				if (ctrl.cache_hit && mem_write)
				begin
					ctrl.write_enable = 1'b1; // byte merge into the hitting way.
					ctrl.valid_in = 1'b1;
					ctrl.dirty_datain = 1'b1;
					ctrl.datain_sel = 1'b1;
				end
			end
			writeback:
			begin
				pmem_write = 1'b1;
				ctrl.pmem_address_sel = 1'b1;
			end
			allocate:
			begin
				pmem_read = 1'b1;
				if (pmem_resp)
				begin
					ctrl.write_enable = 1'b1;
					ctrl.cache_allocate = 1'b1;
					ctrl.valid_in = 1'b1; // a fresh line starts clean.
				end
			end
			default:
				mem_resp = 1'b0;
		endcase
	end

	a_pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else $error("pmem read and write requested together.");

	// the CPU drops its request after a response, so a second pulse is a fault.
	a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |=> !mem_resp)
		else $error("mem_resp held for two cycles.");

endmodule

//--- design/dcache.sv
module dcache
(
	input logic clk,
	input logic rst_n,

	// CPU side.
	input logic mem_read,
	input logic mem_write,
	input lc3b_cache_pkg::lc3b_word mem_address,
	input lc3b_cache_pkg::lc3b_word mem_wdata,
	input lc3b_cache_pkg::lc3b_mem_wmask mem_byte_enable,
	output lc3b_cache_pkg::lc3b_word mem_rdata,
	output logic mem_resp,

	// physical memory side.
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_cache_pkg::lc3b_word pmem_address,
	output lc3b_cache_pkg::pmem_l1_bus pmem_wdata,
	input lc3b_cache_pkg::pmem_l1_bus pmem_rdata,
	input logic pmem_resp
);

	dcache_ctrl_if ctrl_if ();

	dcache_datapath i_datapath
	(
		.clk,
		.rst_n,
		.ctrl(ctrl_if.datapath),
		.mem_read,
		.mem_write,
		.mem_address,
		.mem_wdata,
		.mem_byte_enable,
		.mem_rdata,
		.pmem_address,
		.pmem_rdata,
		.pmem_wdata
	);

	dcache_control i_control
	(
		.clk,
		.rst_n,
		.ctrl(ctrl_if.control),
		.mem_read,
		.mem_write,
		.mem_resp,
		.pmem_resp,
		.pmem_read,
		.pmem_write
	);

endmodule

//--- tb/pmem_model.sv
module pmem_model
#(
	parameter int response_delay = 3
)
(
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_cache_pkg::lc3b_word pmem_address,
	input lc3b_cache_pkg::pmem_l1_bus pmem_wdata,
	output lc3b_cache_pkg::pmem_l1_bus pmem_rdata,
	output logic pmem_resp
);
	import lc3b_cache_pkg::*;

	localparam int words_per_line = $bits(pmem_l1_bus) / $bits(lc3b_word);
	localparam int mem_words = 32768;

	lc3b_word mem [mem_words];
	int wait_count;

	function automatic lc3b_word swap_bytes(input lc3b_word value);
		return {value[7:0], value[15:8]};
	endfunction

	initial
	begin
		pmem_resp <= 1'b0;
		wait_count <= 0;
		for (int i = 0; i < mem_words; i++)
			mem[i] <= swap_bytes(lc3b_word'(i * 2)); // each word holds its own address with the bytes swapped.
	end

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			pmem_resp <= 1'b0;
			wait_count <= 0;
		end
		else
		begin
			pmem_resp <= 1'b0;
			if ((pmem_read || pmem_write) && !pmem_resp)
			begin
				if (wait_count == response_delay - 1)
				begin
					wait_count <= 0;
					pmem_resp <= 1'b1;
					if (pmem_write)
					begin
						for (int w = 0; w < words_per_line; w++)
							mem[{pmem_address[15:4], 3'(w)}] <= pmem_wdata[w*16 +: 16];
					end
				end
				else
					wait_count <= wait_count + 1;
			end
		end
	end

	always_comb
	begin
		for (int w = 0; w < words_per_line; w++)
			pmem_rdata[w*16 +: 16] = mem[{pmem_address[15:4], 3'(w)}];
	end

endmodule

//--- tb/dcache_tb.sv
module dcache_tb;
	import lc3b_cache_pkg::*;

	localparam int pmem_delay = 3;
	localparam int drive_delay = 10;
	localparam int reset_cycles = 10;
	// idle, two checks and the drop cycle, plus one write-back and one allocate.
	localparam int miss_cycles = 4 + 2 * (pmem_delay + 1);

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	lc3b_word mem_address;
	lc3b_word mem_wdata;
	lc3b_mem_wmask mem_byte_enable;
	lc3b_word mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	pmem_l1_bus pmem_wdata;
	pmem_l1_bus pmem_rdata;
	logic pmem_resp;

	string row_name [$];
	bit row_write [$];
	lc3b_word row_addr [$];
	lc3b_word row_wdata [$];
	lc3b_mem_wmask row_mask [$];
	int row_reads [$];
	int row_writes [$];

	lc3b_word shadow [lc3b_word]; // holds each written word under its aligned address.
	string test_name;

	int read_edges = 0;
	int write_edges = 0;
	logic read_q = 1'b0;
	logic write_q = 1'b0;
	int cycle_count = 0;
	int timeout_limit = 0;

	dcache i_dcache (.*);

	pmem_model #(.response_delay(pmem_delay)) i_pmem (.*);

	always #50 clk = ~clk;

	//////////////////////////////////////////////////
	// monitors
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		read_q <= pmem_read;
		write_q <= pmem_write;
		if (pmem_read && !read_q)
			read_edges <= read_edges + 1;
		if (pmem_write && !write_q)
			write_edges <= write_edges + 1;
	end

	always @(negedge clk)
	begin
		if (rst_n && (pmem_read || pmem_write))
			check_value(test_name, "pmem address offset", 32'h0, 32'(pmem_address[3:0]));
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
		begin
			$display("timeout: the cache gave no response within %0d cycles", cycle_count);
			$display("tests failed");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic add_row(input string name, input bit write, input lc3b_word addr,
		input lc3b_word wdata, input lc3b_mem_wmask mask, input int reads, input int writes);
		row_name.push_back(name);
		row_write.push_back(write);
		row_addr.push_back(addr);
		row_wdata.push_back(wdata);
		row_mask.push_back(mask);
		row_reads.push_back(reads);
		row_writes.push_back(writes);
	endtask

	function automatic lc3b_word expected_word(input lc3b_word addr);
		lc3b_word aligned;
		aligned = {addr[15:1], 1'b0};
		if (shadow.exists(aligned))
			return shadow[aligned];
		else
			return {aligned[7:0], aligned[15:8]}; // memory starts byte-swapped.
	endfunction

	task automatic record_write(input lc3b_word addr, input lc3b_word wdata,
		input lc3b_mem_wmask mask);
		lc3b_word word;
		word = expected_word(addr);
		for (int b = 0; b < 2; b++)
		begin
			if (mask[b])
				word[b*8 +: 8] = wdata[b*8 +: 8];
		end
		shadow[{addr[15:1], 1'b0}] = word;
	endtask

	task automatic check_value(input string test_name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch in %s (%s): expected %0h, actual %0h",
				test_name, field, expected, actual);
			$display("tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic run_row(input int i);
		lc3b_word expected;
		int reads_before;
		int writes_before;
		test_name = row_name[i];
		expected = expected_word(row_addr[i]);
		reads_before = read_edges;
		writes_before = write_edges;
		mem_read = !row_write[i];
		mem_write = row_write[i];
		mem_address = row_addr[i];
		mem_wdata = row_wdata[i];
		mem_byte_enable = row_mask[i];
		@(negedge clk);
		while (mem_resp !== 1'b1)
			@(negedge clk);
		if (row_write[i])
			record_write(row_addr[i], row_wdata[i], row_mask[i]);
		else
			check_value(row_name[i], "rdata", 32'(expected), 32'(mem_rdata));
		check_value(row_name[i], "pmem reads", row_reads[i], read_edges - reads_before);
		check_value(row_name[i], "pmem writes", row_writes[i], write_edges - writes_before);
		@(posedge clk);
		#drive_delay;
		mem_read = 1'b0; // request drops in the cycle after mem_resp.
		mem_write = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic build_table();
		// set 1 holds lines A (tag 0), B (tag 1), C (tag 2) and D (tag 3).
		add_row("cold_read", 1'b0, 16'h0012, 16'h0000, 2'b11, 1, 0);
		add_row("read_hit", 1'b0, 16'h0014, 16'h0000, 2'b11, 0, 0);
		add_row("write_low_byte", 1'b1, 16'h0014, 16'habcd, 2'b01, 0, 0);
		add_row("read_merged", 1'b0, 16'h0014, 16'h0000, 2'b11, 0, 0);
		add_row("fill_b", 1'b0, 16'h0096, 16'h0000, 2'b11, 1, 0);
		add_row("touch_a", 1'b0, 16'h0010, 16'h0000, 2'b11, 0, 0);
		add_row("bring_c", 1'b0, 16'h011e, 16'h0000, 2'b11, 1, 0);
		add_row("a_kept", 1'b0, 16'h0012, 16'h0000, 2'b11, 0, 0);
		add_row("touch_c", 1'b0, 16'h0110, 16'h0000, 2'b11, 0, 0);
		add_row("evict_dirty_a", 1'b0, 16'h0190, 16'h0000, 2'b11, 1, 1);
		add_row("reload_a", 1'b0, 16'h0014, 16'h0000, 2'b11, 1, 0);
		// set 2 checks write-allocate and the high byte lane.
		add_row("write_miss", 1'b1, 16'h0220, 16'h5a5a, 2'b11, 1, 0);
		add_row("read_written", 1'b0, 16'h0220, 16'h0000, 2'b11, 0, 0);
		add_row("write_high_byte", 1'b1, 16'h0223, 16'h7700, 2'b10, 0, 0);
		add_row("read_high_merged", 1'b0, 16'h0222, 16'h0000, 2'b11, 0, 0);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		mem_byte_enable = '0;
		build_table();
		timeout_limit = 2 * (reset_cycles + row_name.size() * miss_cycles);
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		rst_n = 1'b1;
		foreach (row_name[i])
		begin
			@(posedge clk);
			#drive_delay;
			run_row(i);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

//--- l1_dcache.f
design/lc3b_cache_pkg.sv
design/dcache_ctrl_if.sv
design/cache_array.sv
design/dcache_datapath.sv
design/dcache_control.sv
design/dcache.sv
tb/pmem_model.sv
tb/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f l1_dcache.f

./obj_dir/Vdcache_tb | tee sim.log

grep -q "all tests passed" sim.log
echo "simulation finished without errors"
